/* common/cpuPkg.sv */
`include "datapath_settings.svh"

package cpuPkg;

    // Machine word carried on every datapath bus
    typedef logic [`DATA_WIDTH-1:0] dataWord;

    // ALU function select, driven each cycle by the control unit
    // Shift and rotate amounts come from the low bits of operand B
    typedef enum logic [3:0] {
        opAdd             = 4'd0,
        opSub             = 4'd1,
        opAnd             = 4'd2,
        opOr              = 4'd3,
        // Logical, zero fill
        opShiftRight      = 4'd4,
        // Sign fill
        opShiftRightArith = 4'd5,
        opShiftLeft       = 4'd6,
        opRotateRight     = 4'd7,
        opRotateLeft      = 4'd8,
        // Unsigned, full 64-bit product
        opMul             = 4'd9,
        // Unsigned, quotient low and remainder high
        opDiv             = 4'd10,
        // Unary ops on operand B
        opNeg             = 4'd11,
        opNot             = 4'd12
    } aluOp;

endpackage

/* common/datapath_settings.svh */
`ifndef DATAPATH_SETTINGS_SVH
`define DATAPATH_SETTINGS_SVH

// Word and register file geometry
`define DATA_WIDTH     32
`define REG_ADDR_WIDTH 4
`define REG_COUNT      16

// Byte distance between consecutive instructions
`define PC_STEP        4

`endif

/* datapath/arithUnit.sv */
`timescale 1ns/1ps

`include "datapath_settings.svh"

module arithUnit (
    input  cpuPkg::aluOp    operation,
    input  cpuPkg::dataWord operandA,
    input  cpuPkg::dataWord operandB,
    output cpuPkg::dataWord resultHigh,
    output cpuPkg::dataWord resultLow,
    output logic            zero,
    output logic            negative
);

    localparam int ShiftBits = $clog2(`DATA_WIDTH);

    logic [ShiftBits-1:0]     shiftAmount;
    logic [2*`DATA_WIDTH-1:0] product;
    logic [2*`DATA_WIDTH-1:0] doubledA;
    logic [2*`DATA_WIDTH-1:0] rotatedRight;
    logic [2*`DATA_WIDTH-1:0] rotatedLeft;
    cpuPkg::dataWord          quotient;
    cpuPkg::dataWord          remainder;

    assign shiftAmount = operandB[ShiftBits-1:0];

    // Full width unsigned product
    assign product = {{`DATA_WIDTH{1'b0}}, operandA} * {{`DATA_WIDTH{1'b0}}, operandB};

    // Rotates work on A placed twice side by side
    assign doubledA     = {operandA, operandA};
    assign rotatedRight = doubledA >> shiftAmount;
    assign rotatedLeft  = doubledA << shiftAmount;

    // Divide by zero gives all ones and passes A through as remainder
    assign quotient  = (operandB == '0) ? '1 : operandA / operandB;
    assign remainder = (operandB == '0) ? operandA : operandA % operandB;

    always_comb begin
        resultHigh = '0;
        case (operation)
            cpuPkg::opSub: begin
                resultLow = operandA - operandB;
            end
            cpuPkg::opAnd: begin
                resultLow = operandA & operandB;
            end
            cpuPkg::opOr: begin
                resultLow = operandA | operandB;
            end
            cpuPkg::opShiftRight: begin
                resultLow = operandA >> shiftAmount;
            end
            cpuPkg::opShiftRightArith: begin
                resultLow = $signed(operandA) >>> shiftAmount;
            end
            cpuPkg::opShiftLeft: begin
                resultLow = operandA << shiftAmount;
            end
            cpuPkg::opRotateRight: begin
                resultLow = rotatedRight[`DATA_WIDTH-1:0];
            end
            cpuPkg::opRotateLeft: begin
                resultLow = rotatedLeft[2*`DATA_WIDTH-1:`DATA_WIDTH];
            end
            cpuPkg::opMul: begin
                resultHigh = product[2*`DATA_WIDTH-1:`DATA_WIDTH];
                resultLow  = product[`DATA_WIDTH-1:0];
            end
            cpuPkg::opDiv: begin
                resultHigh = remainder;
                resultLow  = quotient;
            end
            cpuPkg::opNeg: begin
                resultLow = '0 - operandB;
            end
            cpuPkg::opNot: begin
                resultLow = ~operandB;
            end
            // opAdd and every unassigned code
            default: begin
                resultLow = operandA + operandB;
            end
        endcase
    end

    // Flags follow the low word only
    assign zero     = (resultLow == '0);
    assign negative = resultLow[`DATA_WIDTH-1];

    // Control must never leave the function select floating
    always_comb begin
        operationKnown: assert final (!$isunknown(operation))
            else $error("arithUnit: unknown operation select");
    end

endmodule

/* datapath/datapath.sv */
`timescale 1ns/1ps

`include "datapath_settings.svh"

module datapath (
    input  logic                       Clock,
    input  logic                       reset,
    input  cpuPkg::dataWord            memReadData,
    input  logic                       pcClear,
    input  logic                       pcEnable,
    input  logic                       pcJump,
    input  logic                       pcLoadRegister,
    input  logic                       pcLoadImmediate,
    input  logic                       regWrite,
    input  logic [`REG_ADDR_WIDTH-1:0] regAddrA,
    input  logic [`REG_ADDR_WIDTH-1:0] regAddrB,
    input  logic [`REG_ADDR_WIDTH-1:0] regAddrC,
    input  logic                       writeBackEnable,
    input  cpuPkg::aluOp               aluOperation,
    input  logic                       operandAEnable,
    input  logic                       operandBEnable,
    input  logic                       resultHighEnable,
    input  logic                       resultLowEnable,
    input  logic                       storageEnable,
    input  logic                       bSelect,
    input  logic                       resultHighSelect,
    input  logic                       writeBackFromMemory,
    input  logic                       writeBackFromPc,
    input  logic                       memAddressFromPc,
    input  logic                       storageSelect,
    input  cpuPkg::dataWord            immediate,
    output cpuPkg::dataWord            memAddress,
    output cpuPkg::dataWord            memWriteData,
    output logic                       aluZero,
    output logic                       aluNegative,
    output logic                       jumpZero,
    output logic                       jumpNonZero,
    output logic                       jumpPositive,
    output logic                       jumpNegative
);

    // Register file ports
    cpuPkg::dataWord portA;
    cpuPkg::dataWord portB;

    // ALU outputs before the result registers
    cpuPkg::dataWord aluHigh;
    cpuPkg::dataWord aluLow;

    // Staging registers
    cpuPkg::dataWord operandA;
    cpuPkg::dataWord operandB;
    cpuPkg::dataWord zHigh;
    cpuPkg::dataWord zLow;
    cpuPkg::dataWord storage;
    cpuPkg::dataWord writeBack;

    // Mux outputs feeding the staging registers
    cpuPkg::dataWord operandBNext;
    cpuPkg::dataWord storageNext;
    cpuPkg::dataWord writeBackNext;
    cpuPkg::dataWord pc;

    registerFile regFile (
        .Clock     (Clock),
        .reset     (reset),
        .write     (regWrite),
        .addrA     (regAddrA),
        .addrB     (regAddrB),
        .addrC     (regAddrC),
        .writeData (writeBack),
        .readA     (portA),
        .readB     (portB)
    );

    arithUnit alu (
        .operation  (aluOperation),
        .operandA   (operandA),
        .operandB   (operandB),
        .resultHigh (aluHigh),
        .resultLow  (aluLow),
        .zero       (aluZero),
        .negative   (aluNegative)
    );

    programCounter pcUnit (
        .Clock         (Clock),
        .reset         (reset),
        .clear         (pcClear),
        .enable        (pcEnable),
        .jump          (pcJump),
        .loadRegister  (pcLoadRegister),
        .loadImmediate (pcLoadImmediate),
        .jumpTarget    (operandA),
        .immediate     (immediate),
        .pc            (pc)
    );

    assign operandBNext = bSelect ? immediate : portB;
    assign storageNext  = storageSelect ? zLow : portB;

    // Memory first, then PC, then the result word picked by resultHighSelect
    always_comb begin
        if (writeBackFromMemory) begin
            writeBackNext = memReadData;
        end else if (writeBackFromPc) begin
            writeBackNext = pc;
        end else if (resultHighSelect) begin
            writeBackNext = zHigh;
        end else begin
            writeBackNext = zLow;
        end
    end

    always_ff @(posedge Clock) begin
        if (reset) begin
            operandA  <= '0;
            operandB  <= '0;
            zHigh     <= '0;
            zLow      <= '0;
            storage   <= '0;
            writeBack <= '0;
        end else begin
            if (operandAEnable) begin
                operandA <= portA;
            end
            if (operandBEnable) begin
                operandB <= operandBNext;
            end
            if (resultHighEnable) begin
                zHigh <= aluHigh;
            end
            if (resultLowEnable) begin
                zLow <= aluLow;
            end
            if (storageEnable) begin
                storage <= storageNext;
            end
            if (writeBackEnable) begin
                writeBack <= writeBackNext;
            end
        end
    end

    assign memAddress   = memAddressFromPc ? pc : zLow;
    assign memWriteData = storage;

    // Branch conditions on operand A
    assign jumpZero     = (operandA == '0);
    assign jumpNonZero  = !jumpZero;
    assign jumpNegative = operandA[`DATA_WIDTH-1];
    assign jumpPositive = !jumpZero && !jumpNegative;

    // Write-back has one source at a time
    writeBackSourceOneHot: assert property (
        @(posedge Clock) disable iff (reset)
        !(writeBackFromMemory && writeBackFromPc)
    ) else $error("datapath: write-back from memory and PC selected together");

endmodule

/* datapath/programCounter.sv */
`timescale 1ns/1ps

`include "datapath_settings.svh"

module programCounter (
    input  logic            Clock,
    input  logic            reset,
    input  logic            clear,
    input  logic            enable,
    input  logic            jump,
    input  logic            loadRegister,
    input  logic            loadImmediate,
    input  cpuPkg::dataWord jumpTarget,
    input  cpuPkg::dataWord immediate,
    output cpuPkg::dataWord pc
);

    cpuPkg::dataWord nextPc;

    // Jump with neither load source selected keeps the current address
    always_comb begin
        nextPc = pc;
        if (enable && !jump) begin
            nextPc = pc + `DATA_WIDTH'(`PC_STEP);
        end else if (enable && jump) begin
            if (loadRegister) begin
                nextPc = jumpTarget;
            end else if (loadImmediate) begin
                // Relative to the current address
                nextPc = pc + immediate;
            end
        end
    end

    // Clear wins over any update
    always_ff @(posedge Clock) begin
        if (reset || clear) begin
            pc <= '0;
        end else begin
            pc <= nextPc;
        end
    end

    // Only one jump source may be picked
    singleJumpSource: assert property (
        @(posedge Clock) disable iff (reset)
        jump |-> !(loadRegister && loadImmediate)
    ) else $error("programCounter: register and immediate jump selected together");

endmodule

/* datapath/registerFile.sv */
`timescale 1ns/1ps

`include "datapath_settings.svh"

module registerFile (
    input  logic                       Clock,
    input  logic                       reset,
    input  logic                       write,
    input  logic [`REG_ADDR_WIDTH-1:0] addrA,
    input  logic [`REG_ADDR_WIDTH-1:0] addrB,
    input  logic [`REG_ADDR_WIDTH-1:0] addrC,
    input  cpuPkg::dataWord            writeData,
    output cpuPkg::dataWord            readA,
    output cpuPkg::dataWord            readB
);

    cpuPkg::dataWord registers [`REG_COUNT];

    // Single write port, R0 is hardwired and never stored
    always_ff @(posedge Clock) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                registers[i] <= '0;
            end
        end else if (write && addrC != '0) begin
            registers[addrC] <= writeData;
        end
    end

    // Asynchronous reads see the stored value, so a same-cycle write
    // shows up only after the edge
    assign readA = (addrA == '0) ? '0 : registers[addrA];
    assign readB = (addrB == '0) ? '0 : registers[addrB];

    // Write address must be resolved whenever the control unit writes
    writeAddressKnown: assert property (
        @(posedge Clock) disable iff (reset)
        write |-> !$isunknown(addrC)
    ) else $error("registerFile: unknown write address with write high");

endmodule

/* run.sh */
#!/bin/sh
# Build and run the datapath testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module datapathTb -f vlog.f || exit 1
output=$(./obj_dir/VdatapathTb)
echo "$output"
echo "$output" | grep -qx "Done: no errors" && exit 0 || exit 1

/* test/clockGen.sv */
`timescale 1ns/1ps

module clockGen (
    output logic Clock,
    output logic reset
);

    localparam int ResetCycles = 3;

    // 4 ns period
    initial begin
        Clock = 1'b0;
        forever #2 Clock = ~Clock;
    end

    // Released just after the third rising edge
    initial begin
        reset = 1'b1;
        repeat (ResetCycles) @(posedge Clock);
        #1 reset = 1'b0;
    end

endmodule

/* test/datapathTb.sv */
`timescale 1ns/1ps

`include "datapath_settings.svh"

module datapathTb;

    localparam int ResetTimeout = 20;

    logic                       Clock;
    logic                       reset;
    cpuPkg::dataWord            memReadData;
    logic                       pcClear;
    logic                       pcEnable;
    logic                       pcJump;
    logic                       pcLoadRegister;
    logic                       pcLoadImmediate;
    logic                       regWrite;
    logic [`REG_ADDR_WIDTH-1:0] regAddrA;
    logic [`REG_ADDR_WIDTH-1:0] regAddrB;
    logic [`REG_ADDR_WIDTH-1:0] regAddrC;
    logic                       writeBackEnable;
    cpuPkg::aluOp               aluOperation;
    logic                       operandAEnable;
    logic                       operandBEnable;
    logic                       resultHighEnable;
    logic                       resultLowEnable;
    logic                       storageEnable;
    logic                       bSelect;
    logic                       resultHighSelect;
    logic                       writeBackFromMemory;
    logic                       writeBackFromPc;
    logic                       memAddressFromPc;
    logic                       storageSelect;
    cpuPkg::dataWord            immediate;
    cpuPkg::dataWord            memAddress;
    cpuPkg::dataWord            memWriteData;
    logic                       aluZero;
    logic                       aluNegative;
    logic                       jumpZero;
    logic                       jumpNonZero;
    logic                       jumpPositive;
    logic                       jumpNegative;

    // Expected contents of the register file and staging registers
    cpuPkg::dataWord regModel [`REG_COUNT];
    cpuPkg::dataWord zLowModel;
    cpuPkg::dataWord pcModel;

    clockGen clocks (
        .Clock (Clock),
        .reset (reset)
    );

    datapath DUT (
        .Clock               (Clock),
        .reset               (reset),
        .memReadData         (memReadData),
        .pcClear             (pcClear),
        .pcEnable            (pcEnable),
        .pcJump              (pcJump),
        .pcLoadRegister      (pcLoadRegister),
        .pcLoadImmediate     (pcLoadImmediate),
        .regWrite            (regWrite),
        .regAddrA            (regAddrA),
        .regAddrB            (regAddrB),
        .regAddrC            (regAddrC),
        .writeBackEnable     (writeBackEnable),
        .aluOperation        (aluOperation),
        .operandAEnable      (operandAEnable),
        .operandBEnable      (operandBEnable),
        .resultHighEnable    (resultHighEnable),
        .resultLowEnable     (resultLowEnable),
        .storageEnable       (storageEnable),
        .bSelect             (bSelect),
        .resultHighSelect    (resultHighSelect),
        .writeBackFromMemory (writeBackFromMemory),
        .writeBackFromPc     (writeBackFromPc),
        .memAddressFromPc    (memAddressFromPc),
        .storageSelect       (storageSelect),
        .immediate           (immediate),
        .memAddress          (memAddress),
        .memWriteData        (memWriteData),
        .aluZero             (aluZero),
        .aluNegative         (aluNegative),
        .jumpZero            (jumpZero),
        .jumpNonZero         (jumpNonZero),
        .jumpPositive        (jumpPositive),
        .jumpNegative        (jumpNegative)
    );

    task automatic checkValue(input string name, input cpuPkg::dataWord actual,
                              input cpuPkg::dataWord expected);
        if (actual !== expected) begin
            $display("** Error: %s is %h, expected %h at %0t", name, actual, expected, $time);
            $display("Done: errors found");
            $fatal(1);
        end
    endtask

    // Control unit idle state
    task automatic clearControls();
        memReadData         = '0;
        pcClear             = 1'b0;
        pcEnable            = 1'b0;
        pcJump              = 1'b0;
        pcLoadRegister      = 1'b0;
        pcLoadImmediate     = 1'b0;
        regWrite            = 1'b0;
        regAddrA            = '0;
        regAddrB            = '0;
        regAddrC            = '0;
        writeBackEnable     = 1'b0;
        aluOperation        = cpuPkg::opAdd;
        operandAEnable      = 1'b0;
        operandBEnable      = 1'b0;
        resultHighEnable    = 1'b0;
        resultLowEnable     = 1'b0;
        storageEnable       = 1'b0;
        bSelect             = 1'b0;
        resultHighSelect    = 1'b0;
        writeBackFromMemory = 1'b0;
        writeBackFromPc     = 1'b0;
        memAddressFromPc    = 1'b0;
        storageSelect       = 1'b0;
        immediate           = '0;
    endtask

    // One control step, new strobes go out just after the edge
    task automatic nextCycle();
        @(posedge Clock);
        #1;
        clearControls();
    endtask

    task automatic settle();
        #1;
    endtask

    task automatic waitForReset();
        int cycles;
        cycles = 0;
        while (reset !== 1'b0) begin
            if (cycles == ResetTimeout) begin
                $display("Timeout: reset still asserted after %0d cycles", cycles);
                $display("Done: errors found");
                $fatal(1);
            end
            @(negedge Clock);
            cycles++;
        end
        nextCycle();
    endtask

    // Expected {high, low} result words
    function automatic logic [63:0] modelAlu(input cpuPkg::aluOp op, input cpuPkg::dataWord a,
                                             input cpuPkg::dataWord b);
        logic [4:0]      amount;
        cpuPkg::dataWord fill;
        amount = b[4:0];
        fill   = {32{a[31]}};
        case (op)
            cpuPkg::opSub:             return {32'h0, a - b};
            cpuPkg::opAnd:             return {32'h0, a & b};
            cpuPkg::opOr:              return {32'h0, a | b};
            cpuPkg::opShiftRight:      return {32'h0, a >> amount};
            cpuPkg::opShiftRightArith:
                return {32'h0, (a >> amount) | (~(32'hFFFF_FFFF >> amount) & fill)};
            cpuPkg::opShiftLeft:       return {32'h0, a << amount};
            cpuPkg::opRotateRight:
                return (amount == 5'd0) ? {32'h0, a} :
                    {32'h0, (a >> amount) | (a << (32 - int'(amount)))};
            cpuPkg::opRotateLeft:
                return (amount == 5'd0) ? {32'h0, a} :
                    {32'h0, (a << amount) | (a >> (32 - int'(amount)))};
            cpuPkg::opMul:             return 64'(a) * 64'(b);
            cpuPkg::opDiv:             return (b == 32'h0) ? {a, 32'hFFFF_FFFF} : {a % b, a / b};
            cpuPkg::opNeg:             return {32'h0, ~b + 32'd1};
            cpuPkg::opNot:             return {32'h0, ~b};
            default:                   return {32'h0, a + b};
        endcase
    endfunction

    // Memory word into the write-back register, then into the file
    task automatic loadRegister(input logic [`REG_ADDR_WIDTH-1:0] addr,
                                input cpuPkg::dataWord value);
        memReadData         = value;
        writeBackFromMemory = 1'b1;
        writeBackEnable     = 1'b1;
        nextCycle();
        regWrite = 1'b1;
        regAddrC = addr;
        nextCycle();
        if (addr != '0) begin
            regModel[addr] = value;
        end
    endtask

    // Port B through the storage register onto memWriteData
    task automatic readRegister(input logic [`REG_ADDR_WIDTH-1:0] addr,
                                output cpuPkg::dataWord value);
        regAddrB      = addr;
        storageEnable = 1'b1;
        nextCycle();
        settle();
        value = memWriteData;
    endtask

    task automatic checkRegister(input logic [`REG_ADDR_WIDTH-1:0] addr);
        cpuPkg::dataWord value;
        readRegister(addr, value);
        checkValue($sformatf("R%0d", addr), value, regModel[addr]);
    endtask

    // Operands, result, write-back, register write
    task automatic runOperation(input cpuPkg::aluOp op, input logic [`REG_ADDR_WIDTH-1:0] ra,
                                input logic [`REG_ADDR_WIDTH-1:0] rb,
                                input logic [`REG_ADDR_WIDTH-1:0] rc,
                                input logic useImmediate, input cpuPkg::dataWord imm,
                                input logic takeHigh);
        logic [63:0] expected;
        expected = modelAlu(op, regModel[ra], useImmediate ? imm : regModel[rb]);
        regAddrA       = ra;
        regAddrB       = rb;
        bSelect        = useImmediate;
        immediate      = imm;
        operandAEnable = 1'b1;
        operandBEnable = 1'b1;
        nextCycle();
        aluOperation     = op;
        resultHighEnable = 1'b1;
        resultLowEnable  = 1'b1;
        settle();
        checkValue("aluZero", 32'(aluZero), 32'(expected[31:0] == 32'h0));
        checkValue("aluNegative", 32'(aluNegative), 32'(expected[31]));
        nextCycle();
        zLowModel        = expected[31:0];
        writeBackEnable  = 1'b1;
        resultHighSelect = takeHigh;
        nextCycle();
        regWrite = 1'b1;
        regAddrC = rc;
        nextCycle();
        if (rc != '0) begin
            regModel[rc] = takeHigh ? expected[63:32] : expected[31:0];
        end
    endtask

    task automatic compareBranchFlags(input cpuPkg::dataWord a);
        checkValue("jumpZero", 32'(jumpZero), 32'(a == 32'h0));
        checkValue("jumpNonZero", 32'(jumpNonZero), 32'(a != 32'h0));
        checkValue("jumpPositive", 32'(jumpPositive), 32'(a != 32'h0 && !a[31]));
        checkValue("jumpNegative", 32'(jumpNegative), 32'(a[31]));
    endtask

    task automatic checkPcAddress();
        memAddressFromPc = 1'b1;
        settle();
        checkValue("memAddress", memAddress, pcModel);
    endtask

    task automatic testReset();
        settle();
        checkValue("memAddress", memAddress, 32'h0);
        checkValue("memWriteData", memWriteData, 32'h0);
        checkValue("aluZero", 32'(aluZero), 32'd1);
        checkValue("aluNegative", 32'(aluNegative), 32'd0);
        compareBranchFlags(32'h0);
        checkRegister(4'd0);
        // R0 ignores writes
        loadRegister(4'd0, $urandom() | 32'd1);
        checkRegister(4'd0);
    endtask

    task automatic testLoads();
        loadRegister(4'd3, $urandom());
        loadRegister(4'd5, $urandom());
        checkRegister(4'd3);
        checkRegister(4'd5);
        for (int i = 1; i < `REG_COUNT; i++) begin
            loadRegister(4'(i), $urandom());
        end
        for (int i = 0; i < `REG_COUNT; i++) begin
            checkRegister(4'(i));
        end
    endtask

    task automatic testRegisterOps();
        cpuPkg::aluOp ops [6] = '{cpuPkg::opAdd, cpuPkg::opSub, cpuPkg::opAnd,
                                  cpuPkg::opOr, cpuPkg::opNeg, cpuPkg::opNot};
        for (int i = 0; i < 6; i++) begin
            loadRegister(4'd1, $urandom());
            loadRegister(4'd2, $urandom());
            runOperation(ops[i], 4'd1, 4'd2, 4'(6 + i), 1'b0, 32'h0, 1'b0);
            checkRegister(4'(6 + i));
        end
        // Zero result and a small negated value
        runOperation(cpuPkg::opSub, 4'd1, 4'd1, 4'd12, 1'b0, 32'h0, 1'b0);
        checkRegister(4'd12);
        loadRegister(4'd2, 32'd5);
        runOperation(cpuPkg::opNeg, 4'd1, 4'd2, 4'd13, 1'b0, 32'h0, 1'b0);
        checkRegister(4'd13);
    endtask

    task automatic testShiftsMulDiv();
        cpuPkg::aluOp shifts [5] = '{cpuPkg::opShiftRight, cpuPkg::opShiftRightArith,
                                     cpuPkg::opShiftLeft, cpuPkg::opRotateRight,
                                     cpuPkg::opRotateLeft};
        loadRegister(4'd1, $urandom() | 32'h8000_0000);
        for (int i = 0; i < 5; i++) begin
            runOperation(shifts[i], 4'd1, 4'd0, 4'd7, 1'b1, $urandom(), 1'b0);
            checkRegister(4'd7);
        end
        loadRegister(4'd1, $urandom());
        loadRegister(4'd2, ($urandom() >> 16) + 32'd1);
        for (int high = 0; high < 2; high++) begin
            runOperation(cpuPkg::opMul, 4'd1, 4'd2, 4'd8, 1'b0, 32'h0, 1'(high));
            checkRegister(4'd8);
            runOperation(cpuPkg::opDiv, 4'd1, 4'd2, 4'd9, 1'b0, 32'h0, 1'(high));
            checkRegister(4'd9);
            // R0 as divisor
            runOperation(cpuPkg::opDiv, 4'd1, 4'd0, 4'd10, 1'b0, 32'h0, 1'(high));
            checkRegister(4'd10);
        end
    endtask

    task automatic testProgramCounter();
        cpuPkg::dataWord target;
        pcClear = 1'b1;
        nextCycle();
        pcModel = 32'h0;
        checkPcAddress();
        repeat (3) begin
            pcEnable = 1'b1;
            nextCycle();
            pcModel = pcModel + `PC_STEP;
            checkPcAddress();
        end
        target = $urandom() & ~32'h3;
        loadRegister(4'd4, target);
        regAddrA       = 4'd4;
        operandAEnable = 1'b1;
        nextCycle();
        pcEnable       = 1'b1;
        pcJump         = 1'b1;
        pcLoadRegister = 1'b1;
        nextCycle();
        pcModel = target;
        checkPcAddress();
        // Backwards by four words
        pcEnable        = 1'b1;
        pcJump          = 1'b1;
        pcLoadImmediate = 1'b1;
        immediate       = 32'hFFFF_FFF0;
        nextCycle();
        pcModel = pcModel + 32'hFFFF_FFF0;
        checkPcAddress();
        writeBackFromPc = 1'b1;
        writeBackEnable = 1'b1;
        nextCycle();
        regWrite = 1'b1;
        regAddrC = 4'd11;
        nextCycle();
        regModel[11] = pcModel;
        checkRegister(4'd11);
        checkValue("memAddress", memAddress, zLowModel);
        // Storage register fed from ZLow instead of port B
        storageSelect = 1'b1;
        storageEnable = 1'b1;
        nextCycle();
        settle();
        checkValue("memWriteData", memWriteData, zLowModel);
        // Clear beats increment
        pcClear  = 1'b1;
        pcEnable = 1'b1;
        nextCycle();
        pcModel = 32'h0;
        checkPcAddress();
    endtask

    task automatic testBranchFlags();
        cpuPkg::dataWord values [3];
        values[0] = 32'h0;
        values[1] = ($urandom() >> 1) | 32'd1;
        values[2] = $urandom() | 32'h8000_0000;
        for (int i = 0; i < 3; i++) begin
            loadRegister(4'd14, values[i]);
            regAddrA       = 4'd14;
            operandAEnable = 1'b1;
            nextCycle();
            settle();
            compareBranchFlags(values[i]);
        end
    endtask

    initial begin
        void'($urandom(32'h8b320569));
        for (int i = 0; i < `REG_COUNT; i++) begin
            regModel[i] = '0;
        end
        zLowModel = '0;
        pcModel   = '0;
        clearControls();
        waitForReset();
        testReset();
        testLoads();
        testRegisterOps();
        testShiftsMulDiv();
        testProgramCounter();
        testBranchFlags();
        $display("Done: no errors");
        $finish;
    end

endmodule

/* vlog.f */
+incdir+common
common/cpuPkg.sv
datapath/registerFile.sv
datapath/arithUnit.sv
datapath/programCounter.sv
datapath/datapath.sv
test/clockGen.sv
test/datapathTb.sv
